// File: tb.f
+incdir+verilog
verilog/ex_pkg.sv
verilog/alu.sv
verilog/mul_unit.sv
verilog/ex_control.sv
verilog/ex_stage.sv
verilog/mem_wb_stage.sv
verilog/ex_pipe_top.sv
tests/tb_ex_pipe.sv

// File: run.sh
#!/bin/sh
# Build and run the EX pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_ex_pipe -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
    echo "run.sh: failure reported"
    exit 1
fi
exit 0

// File: tests/tb_ex_pipe.sv
`timescale 1ns/10ps
`include "ex_macros.svh"

module tb_ex_pipe;

    localparam logic [6:0] OPC_OP    = 7'b0110011;
    localparam logic [6:0] OPC_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_LUI   = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;
    localparam logic [6:0] OPC_BR    = 7'b1100011;

    typedef struct {
        int          test;
        logic [31:0] inst;
        logic [31:0] rd1;
        logic [31:0] rd2;
        logic [31:0] imm;
        logic [31:0] pc;
        logic        pred;
        logic        stale_a;
        logic        stale_b;
    } row_t;

    typedef struct {
        logic [31:0] inst;
        logic [31:0] data;
    } ret_t;

    typedef struct {
        logic [31:0] pc;
        logic [31:0] target;
        logic        mis;
    } br_t;

    logic        clk = 1'b0;
    logic        arst_n;
    logic [31:0] ex_pc;
    logic [31:0] ex_rd1;
    logic [31:0] ex_rd2;
    logic [31:0] ex_imm;
    logic [31:0] ex_inst;
    logic        ex_br_taken;
    logic        ex_stall;
    logic [31:0] mem_pc;
    logic [31:0] mem_alu;
    logic [31:0] mem_inst;
    logic        mem_br_suc;
    logic        mem_redirect_taken;
    logic        mem_flush;
    logic [31:0] wb_wdata;
    logic [31:0] wb_inst;

    row_t        rows[$];
    ret_t        exp_q[$];
    br_t         br_q[$];
    // Program-order model and retired register file seen by decode
    logic [31:0] spec_rf[32];
    logic [31:0] rf_ret[32];
    logic        squash_next = 1'b0;
    integer      seed = 32'hf8dbf7cf;
    int          errors = 0;
    int          failed_tests = 0;
    int          stall_cnt = 0;
    int          exp_stalls = 0;
    int          cycles = 0;
    int          limit = 0;
    string       names[6];

    ex_pipe_top dut_i (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] enc(input int f7, input int rs2, input int rs1,
                                        input int f3, input int rd, input logic [6:0] op);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] sext12(input logic [31:0] v);
        return {{20{v[11]}}, v[11:0]};
    endfunction

    // RV32IM result rules for the supported groups
    function automatic logic [31:0] alu_model(input logic [31:0] inst, input logic [31:0] a,
                                              input logic [31:0] rb, input logic [31:0] imm,
                                              input logic [31:0] pc);
        logic [31:0] b;
        logic        alt;
        alt = inst[30];
        if (inst[6:0] == OPC_LUI)
            return imm;
        if (inst[6:0] == OPC_AUIPC)
            return pc + imm;
        if (inst[6:0] == OPC_OP && inst[31:25] == 7'd1)
            return a * rb;
        b = (inst[6:0] == OPC_OP) ? rb : imm;
        case (inst[14:12])
            3'd0: return (inst[6:0] == OPC_OP && alt) ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'd0, $signed(a) < $signed(b)};
            3'd3: return {31'd0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_model(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic add_row(input int test, input logic [31:0] inst, input logic [31:0] imm,
                           input logic [31:0] pc, input logic pred, input logic sa,
                           input logic sb);
        row_t r;
        r.test = test;
        r.inst = inst;
        // Garbage register reads, only used where forwarding must override them
        r.rd1 = 32'hbad00000 + 32'(rows.size());
        r.rd2 = 32'hbad10000 + 32'(rows.size());
        r.imm = imm;
        r.pc = pc;
        r.pred = pred;
        r.stale_a = sa;
        r.stale_b = sb;
        rows.push_back(r);
    endtask

    task automatic build_table;
        logic [31:0] rnd;
        // ALU coverage, x1..x3 seed the operands
        add_row(1, enc(0, 0, 0, 0, 1, OPC_LUI), 32'h8f0f0000, 32'h0, 0, 0, 0);
        add_row(1, enc(0, 0, 0, 0, 2, OPC_IMM), 32'h123, 32'h4, 0, 0, 0);
        add_row(1, enc(0, 0, 0, 0, 3, OPC_IMM), 32'hfffffffb, 32'h8, 0, 0, 0);
        add_row(1, enc(0, 2, 1, 0, 4, OPC_OP), 0, 32'hc, 0, 0, 0);
        add_row(1, enc(32, 3, 2, 0, 5, OPC_OP), 0, 32'h10, 0, 0, 0);
        add_row(1, enc(0, 3, 2, 1, 6, OPC_OP), 0, 32'h14, 0, 0, 0);
        add_row(1, enc(0, 2, 1, 2, 7, OPC_OP), 0, 32'h18, 0, 0, 0);
        add_row(1, enc(0, 2, 1, 3, 8, OPC_OP), 0, 32'h1c, 0, 0, 0);
        add_row(1, enc(0, 2, 1, 4, 9, OPC_OP), 0, 32'h20, 0, 0, 0);
        add_row(1, enc(0, 3, 1, 5, 10, OPC_OP), 0, 32'h24, 0, 0, 0);
        add_row(1, enc(32, 3, 1, 5, 11, OPC_OP), 0, 32'h28, 0, 0, 0);
        add_row(1, enc(0, 2, 1, 6, 12, OPC_OP), 0, 32'h2c, 0, 0, 0);
        add_row(1, enc(0, 2, 1, 7, 13, OPC_OP), 0, 32'h30, 0, 0, 0);
        add_row(1, enc(0, 0, 3, 2, 14, OPC_IMM), 32'h1, 32'h34, 0, 0, 0);
        add_row(1, enc(0, 0, 3, 3, 15, OPC_IMM), 32'h1, 32'h38, 0, 0, 0);
        rnd = $random(seed);
        add_row(1, enc(0, 0, 1, 4, 16, OPC_IMM), sext12(rnd), 32'h3c, 0, 0, 0);
        rnd = $random(seed);
        add_row(1, enc(0, 0, 1, 6, 17, OPC_IMM), sext12(rnd), 32'h40, 0, 0, 0);
        rnd = $random(seed);
        add_row(1, enc(0, 0, 1, 7, 18, OPC_IMM), sext12(rnd), 32'h44, 0, 0, 0);
        add_row(1, enc(0, 4, 2, 1, 19, OPC_IMM), 32'h4, 32'h48, 0, 0, 0);
        add_row(1, enc(0, 4, 1, 5, 20, OPC_IMM), 32'h4, 32'h4c, 0, 0, 0);
        add_row(1, enc(32, 4, 1, 5, 21, OPC_IMM), 32'h404, 32'h50, 0, 0, 0);
        rnd = $random(seed);
        add_row(1, enc(0, 0, 1, 0, 22, OPC_IMM), sext12(rnd), 32'h54, 0, 0, 0);
        add_row(1, enc(0, 0, 0, 0, 23, OPC_AUIPC), 32'h1000, 32'h100, 0, 0, 0);
        // Dependency chains with stale register reads
        add_row(2, enc(0, 0, 0, 0, 24, OPC_IMM), 32'h7, 32'h104, 0, 0, 0);
        add_row(2, enc(0, 24, 24, 0, 25, OPC_OP), 0, 32'h108, 0, 1, 1);
        add_row(2, enc(0, 25, 24, 0, 26, OPC_OP), 0, 32'h10c, 0, 1, 1);
        add_row(2, enc(0, 26, 25, 0, 0, OPC_OP), 0, 32'h110, 0, 1, 1);
        add_row(2, enc(0, 26, 0, 0, 27, OPC_OP), 0, 32'h114, 0, 0, 1);
        // x27 sits in both MEM and WB, the younger one must win
        add_row(2, enc(0, 0, 27, 0, 27, OPC_IMM), 32'h3, 32'h118, 0, 1, 0);
        add_row(2, enc(0, 27, 27, 0, 9, OPC_OP), 0, 32'h11c, 0, 1, 1);
        // Multiplier, dependents right behind it
        rnd = $random(seed);
        add_row(3, enc(0, 0, 0, 0, 28, OPC_LUI), {rnd[31:12], 12'd0}, 32'h120, 0, 0, 0);
        rnd = $random(seed);
        add_row(3, enc(0, 0, 0, 0, 29, OPC_IMM), sext12(rnd), 32'h124, 0, 0, 0);
        add_row(3, enc(1, 29, 28, 0, 30, OPC_OP), 0, 32'h128, 0, 1, 1);
        add_row(3, enc(0, 28, 30, 0, 31, OPC_OP), 0, 32'h12c, 0, 1, 0);
        add_row(3, enc(0, 0, 31, 0, 1, OPC_IMM), 32'h1, 32'h130, 0, 1, 0);
        add_row(3, enc(1, 30, 30, 0, 2, OPC_OP), 0, 32'h134, 0, 0, 0);
        add_row(3, enc(1, 1, 2, 0, 3, OPC_OP), 0, 32'h138, 0, 1, 0);
        add_row(3, enc(0, 0, 3, 0, 4, OPC_IMM), 32'h5, 32'h13c, 0, 1, 0);
        // Correct predictions, x24 = 7, x25 = 14, x11 negative
        add_row(4, enc(0, 24, 24, 0, 0, OPC_BR), 32'h40, 32'h200, 1, 0, 0);
        add_row(4, enc(0, 25, 24, 1, 0, OPC_BR), 32'h40, 32'h240, 1, 0, 0);
        add_row(4, enc(0, 24, 11, 4, 0, OPC_BR), 32'h80, 32'h280, 1, 0, 0);
        add_row(4, enc(0, 24, 11, 5, 0, OPC_BR), 32'h80, 32'h300, 0, 0, 0);
        add_row(4, enc(0, 24, 11, 6, 0, OPC_BR), 32'h80, 32'h304, 0, 0, 0);
        add_row(4, enc(0, 24, 11, 7, 0, OPC_BR), 32'hfffffff0, 32'h308, 1, 0, 0);
        add_row(4, enc(0, 0, 4, 0, 4, OPC_IMM), 32'h1, 32'h2f8, 0, 0, 0);
        // Mispredictions, the row right after each one is wrong-path
        add_row(5, enc(0, 25, 24, 0, 0, OPC_BR), 32'h40, 32'h400, 1, 0, 0);
        add_row(5, enc(0, 0, 0, 0, 5, OPC_IMM), 32'h63, 32'h440, 0, 0, 0);
        add_row(5, enc(0, 0, 0, 0, 6, OPC_IMM), 32'h1, 32'h404, 0, 0, 0);
        add_row(5, enc(0, 24, 11, 4, 0, OPC_BR), 32'h100, 32'h408, 0, 0, 0);
        add_row(5, enc(0, 6, 6, 0, 7, OPC_OP), 0, 32'h40c, 0, 0, 0);
        add_row(5, enc(0, 24, 24, 0, 8, OPC_OP), 0, 32'h508, 0, 0, 0);
    endtask

    task automatic apply_row(input row_t r);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic        taken;
        ret_t        e;
        br_t         bx;
        a = spec_rf[r.inst[19:15]];
        b = spec_rf[r.inst[24:20]];
        if (squash_next) begin
            squash_next = 1'b0;
        end else if (r.inst[6:0] == OPC_BR) begin
            taken = branch_model(r.inst[14:12], a, b);
            res = taken ? r.pc + r.imm : r.pc + 32'd4;
            e.inst = r.inst;
            e.data = res;
            exp_q.push_back(e);
            bx.pc = r.pc;
            bx.target = res;
            bx.mis = (taken != r.pred);
            br_q.push_back(bx);
            squash_next = (taken != r.pred);
        end else begin
            res = alu_model(r.inst, a, b, r.imm, r.pc);
            e.inst = r.inst;
            e.data = res;
            exp_q.push_back(e);
            if (r.inst[11:7] != 5'd0)
                spec_rf[r.inst[11:7]] = res;
            if (r.inst[6:0] == OPC_OP && r.inst[31:25] == 7'd1)
                exp_stalls += `MUL_CYCLES;
        end
        @(posedge clk);
        ex_inst <= r.inst;
        ex_pc <= r.pc;
        ex_imm <= r.imm;
        ex_br_taken <= r.pred;
        ex_rd1 <= r.stale_a ? r.rd1 : rf_ret[r.inst[19:15]];
        ex_rd2 <= r.stale_b ? r.rd2 : rf_ret[r.inst[24:20]];
        // Hold the row while the multiplier runs
        @(negedge clk);
        while (ex_stall)
            @(negedge clk);
    endtask

    // Retirement scoreboard and MEM-stage branch checks
    always @(negedge clk) begin
        ret_t e;
        br_t  bx;
        if (arst_n) begin
            if (ex_stall)
                stall_cnt++;
            if (wb_inst != `NOP) begin
                if (exp_q.size() == 0) begin
                    $display("Unexpected retirement of instruction %h", wb_inst);
                    errors++;
                end else begin
                    e = exp_q.pop_front();
                    assert (wb_inst == e.inst) else begin
                        $display("Mismatch wb_inst: got %h expected %h", wb_inst, e.inst);
                        errors++;
                    end
                    assert (wb_wdata == e.data) else begin
                        $display("Mismatch wb_wdata: got %h expected %h", wb_wdata, e.data);
                        errors++;
                    end
                end
                if (wb_inst[6:0] != OPC_BR && wb_inst[11:7] != 5'd0)
                    rf_ret[wb_inst[11:7]] = wb_wdata;
            end
            if (mem_inst[6:0] == OPC_BR && br_q.size() != 0) begin
                bx = br_q.pop_front();
                assert (mem_pc == bx.pc) else begin
                    $display("Mismatch mem_pc: got %h expected %h", mem_pc, bx.pc);
                    errors++;
                end
                assert (mem_alu == bx.target) else begin
                    $display("Mismatch mem_alu: got %h expected %h", mem_alu, bx.target);
                    errors++;
                end
                assert (mem_redirect_taken == bx.mis && mem_flush == bx.mis &&
                        mem_br_suc == !bx.mis) else begin
                    $display("Mismatch mem_redirect_taken/mem_flush/mem_br_suc: %s",
                             $sformatf("got %h/%h/%h expected %h/%h/%h",
                                       mem_redirect_taken, mem_flush, mem_br_suc,
                                       bx.mis, bx.mis, !bx.mis));
                    errors++;
                end
            end else begin
                assert (!mem_flush && !mem_redirect_taken && !mem_br_suc) else begin
                    $display("Branch flags raised with no branch in MEM");
                    errors++;
                end
            end
        end
    end

    // Run limit from table length
    always @(negedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("Timeout after %0d cycles, pipeline stopped retiring", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        int err0;
        int st0;
        arst_n = 1'b0;
        ex_pc = '0;
        ex_rd1 = '0;
        ex_rd2 = '0;
        ex_imm = '0;
        ex_inst = `NOP;
        ex_br_taken = 1'b0;
        for (int i = 0; i < 32; i++) begin
            spec_rf[i] = '0;
            rf_ret[i] = '0;
        end
        names = '{"reset", "alu ops", "forwarding", "multiply",
                  "predicted branches", "mispredicted branches"};
        build_table();
        limit = rows.size() * (`MUL_CYCLES + 4) + 20;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        err0 = errors;
        assert (!ex_stall && !mem_flush && !mem_redirect_taken && !mem_br_suc) else begin
            $display("Flags not low after reset");
            errors++;
        end
        assert (wb_inst == `NOP) else begin
            $display("Mismatch wb_inst: got %h expected %h", wb_inst, `NOP);
            errors++;
        end
        $display("Test 0 %s: %s", names[0], (errors == err0) ? "ok" : "FAILED");
        if (errors != err0)
            failed_tests++;
        for (int t = 1; t <= 5; t++) begin
            err0 = errors;
            st0 = stall_cnt;
            exp_stalls = 0;
            foreach (rows[i])
                if (rows[i].test == t)
                    apply_row(rows[i]);
            @(posedge clk);
            ex_inst <= `NOP;
            ex_br_taken <= 1'b0;
            while (exp_q.size() != 0 || br_q.size() != 0)
                @(negedge clk);
            assert (stall_cnt - st0 == exp_stalls) else begin
                $display("Mismatch ex_stall cycles: got %h expected %h",
                         stall_cnt - st0, exp_stalls);
                errors++;
            end
            $display("Test %0d %s: %s", t, names[t], (errors == err0) ? "ok" : "FAILED");
            if (errors != err0)
                failed_tests++;
        end
        $display("Tests run 6, failed %0d, errors %0d", failed_tests, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: verilog/ex_pipe_top.sv
`timescale 1ns/10ps
`include "ex_macros.svh"

module ex_pipe_top (
    input  logic             clk,
    input  logic             arst_n,
    input  logic [`XLEN-1:0] ex_pc,
    input  logic [`XLEN-1:0] ex_rd1,
    input  logic [`XLEN-1:0] ex_rd2,
    input  logic [`XLEN-1:0] ex_imm,
    input  logic [`XLEN-1:0] ex_inst,
    input  logic             ex_br_taken,
    output logic             ex_stall,
    output logic [`XLEN-1:0] mem_pc,
    output logic [`XLEN-1:0] mem_alu,
    output logic [`XLEN-1:0] mem_inst,
    output logic             mem_br_suc,
    output logic             mem_redirect_taken,
    output logic             mem_flush,
    output logic [`XLEN-1:0] wb_wdata,
    output logic [`XLEN-1:0] wb_inst
);

    // EX stage, WB feeds back for forwarding
    ex_stage ex (
        .clk(clk),
        .arst_n(arst_n),
        .ex_pc(ex_pc),
        .ex_rd1(ex_rd1),
        .ex_rd2(ex_rd2),
        .ex_imm(ex_imm),
        .ex_inst(ex_inst),
        .ex_br_taken(ex_br_taken),
        .wb_wdata(wb_wdata),
        .wb_inst(wb_inst),
        .ex_stall(ex_stall),
        .mem_pc(mem_pc),
        .mem_alu(mem_alu),
        .mem_inst(mem_inst),
        .mem_br_suc(mem_br_suc),
        .mem_redirect_taken(mem_redirect_taken),
        .mem_flush(mem_flush)
    );

    mem_wb_stage mem_wb (
        .clk(clk),
        .arst_n(arst_n),
        .mem_alu(mem_alu),
        .mem_inst(mem_inst),
        .wb_wdata(wb_wdata),
        .wb_inst(wb_inst)
    );

endmodule

// File: verilog/mem_wb_stage.sv
`timescale 1ns/10ps
`include "ex_macros.svh"

module mem_wb_stage (
    input  logic             clk,
    input  logic             arst_n,
    input  logic [`XLEN-1:0] mem_alu,
    input  logic [`XLEN-1:0] mem_inst,
    output logic [`XLEN-1:0] wb_wdata,
    output logic [`XLEN-1:0] wb_inst
);

    // No loads, MEM result passes straight to WB
    // wb_inst also drives second-level hazard match in EX
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_inst <= `NOP;
        end else begin
            wb_inst <= mem_inst;
        end
    end

    // Write-back data, also the WB forward source
    always_ff @(posedge clk) begin
        wb_wdata <= mem_alu;
    end

endmodule

// File: verilog/ex_stage.sv
`timescale 1ns/10ps
`include "ex_macros.svh"

module ex_stage (
    input  logic             clk,
    input  logic             arst_n,
    input  logic [`XLEN-1:0] ex_pc,
    input  logic [`XLEN-1:0] ex_rd1,
    input  logic [`XLEN-1:0] ex_rd2,
    input  logic [`XLEN-1:0] ex_imm,
    input  logic [`XLEN-1:0] ex_inst,
    input  logic             ex_br_taken,
    input  logic [`XLEN-1:0] wb_wdata,
    input  logic [`XLEN-1:0] wb_inst,
    output logic             ex_stall,
    output logic [`XLEN-1:0] mem_pc,
    output logic [`XLEN-1:0] mem_alu,
    output logic [`XLEN-1:0] mem_inst,
    output logic             mem_br_suc,
    output logic             mem_redirect_taken,
    output logic             mem_flush
);

    ex_pkg::fwd_sel_e fwda_sel;
    ex_pkg::fwd_sel_e fwdb_sel;
    ex_pkg::a_sel_e   a_sel;
    ex_pkg::b_sel_e   b_sel;
    ex_pkg::alu_op_e  alu_sel;
    logic [`XLEN-1:0] fwda_out;
    logic [`XLEN-1:0] fwdb_out;
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    logic [`XLEN-1:0] ex_alu;
    logic [`XLEN-1:0] mul_res;
    logic [`XLEN-1:0] ex_res;
    logic             brun;
    logic             breq;
    logic             brlt;
    logic             mul_start;
    logic             mul_go;
    logic             mul_busy;
    logic             use_mul;
    logic             redirect_pc;
    logic             br_suc;
    logic             flush;
    logic             bubble;

    function automatic logic [`XLEN-1:0] fwd_mux(
        input ex_pkg::fwd_sel_e sel,
        input logic [`XLEN-1:0] rf,
        input logic [`XLEN-1:0] mem,
        input logic [`XLEN-1:0] wb
    );
        case (sel)
            ex_pkg::FWD_MEM: return mem;
            ex_pkg::FWD_WB:  return wb;
            default:         return rf;
        endcase
    endfunction

    // Forwarding, MEM result then WB data
    assign fwda_out = fwd_mux(fwda_sel, ex_rd1, mem_alu, wb_wdata);
    assign fwdb_out = fwd_mux(fwdb_sel, ex_rd2, mem_alu, wb_wdata);

    assign a = (a_sel == ex_pkg::A_PC) ? ex_pc : fwda_out;

    always_comb begin
        case (b_sel)
            ex_pkg::B_IMM:  b = ex_imm;
            ex_pkg::B_FOUR: b = `XLEN'd4;
            default:        b = fwdb_out;
        endcase
    end

    ex_control control (
        .clk(clk),
        .arst_n(arst_n),
        .inst(ex_inst),
        .mem_inst(mem_inst),
        .wb_inst(wb_inst),
        .breq(breq),
        .brlt(brlt),
        .br_taken(ex_br_taken),
        .mul_busy(mul_busy),
        .brun(brun),
        .fwda(fwda_sel),
        .fwdb(fwdb_sel),
        .asel(a_sel),
        .bsel(b_sel),
        .alusel(alu_sel),
        .mul_start(mul_start),
        .use_mul(use_mul),
        .redirect_pc(redirect_pc),
        .br_suc(br_suc),
        .flush(flush)
    );

    // Result and target path
    alu alu_i (
        .a(a),
        .b(b),
        .sel(alu_sel),
        .un(brun),
        .res(ex_alu),
        .eq(),
        .lt()
    );

    // Comparator sees forwarded registers, not pc/imm
    alu br_cmp (
        .a(fwda_out),
        .b(fwdb_out),
        .sel(ex_pkg::SUB),
        .un(brun),
        .res(),
        .eq(breq),
        .lt(brlt)
    );

    // Wrong-path MUL must not start
    assign mul_go = mul_start & ~mem_flush;

    mul_unit mul (
        .clk(clk),
        .arst_n(arst_n),
        .a(fwda_out),
        .b(fwdb_out),
        .start(mul_go),
        .res(mul_res),
        .busy(mul_busy)
    );

    assign ex_stall = mul_busy;
    assign ex_res = use_mul ? mul_res : ex_alu;

    // Squash on stall or on flush from the branch now in MEM
    assign bubble = ex_stall | mem_flush;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_inst <= `NOP;
            mem_br_suc <= 1'b0;
            mem_redirect_taken <= 1'b0;
            mem_flush <= 1'b0;
        end else if (bubble) begin
            mem_inst <= `NOP;
            mem_br_suc <= 1'b0;
            mem_redirect_taken <= 1'b0;
            mem_flush <= 1'b0;
        end else begin
            mem_inst <= ex_inst;
            mem_br_suc <= br_suc;
            mem_redirect_taken <= redirect_pc;
            mem_flush <= flush;
        end
    end

    // Payload, only meaningful alongside mem_inst
    always_ff @(posedge clk) begin
        mem_pc <= ex_pc;
        mem_alu <= ex_res;
    end

endmodule

// File: verilog/ex_control.sv
`timescale 1ns/10ps
`include "ex_macros.svh"

module ex_control (
    input  logic               clk,
    input  logic               arst_n,
    input  logic [`XLEN-1:0]   inst,
    input  logic [`XLEN-1:0]   mem_inst,
    input  logic [`XLEN-1:0]   wb_inst,
    input  logic               breq,
    input  logic               brlt,
    input  logic               br_taken,
    input  logic               mul_busy,
    output logic               brun,
    output ex_pkg::fwd_sel_e   fwda,
    output ex_pkg::fwd_sel_e   fwdb,
    output ex_pkg::a_sel_e     asel,
    output ex_pkg::b_sel_e     bsel,
    output ex_pkg::alu_op_e    alusel,
    output logic               mul_start,
    output logic               use_mul,
    output logic               redirect_pc,
    output logic               br_suc,
    output logic               flush
);

    ex_pkg::opcode_e opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic            is_branch;
    logic            br_actual;
    logic            busy_q;

    // Only OP, OP-IMM, LUI, AUIPC write rd; x0 never counts
    function automatic logic writes_rd(input logic [`XLEN-1:0] i);
        ex_pkg::opcode_e op;
        op = ex_pkg::opcode_e'(i[6:0]);
        return (i[11:7] != 5'd0) &&
               (op == ex_pkg::OP || op == ex_pkg::OP_IMM ||
                op == ex_pkg::LUI || op == ex_pkg::AUIPC);
    endfunction

    // MEM has priority, it holds the younger value
    function automatic ex_pkg::fwd_sel_e fwd_pick(
        input logic [4:0]       rs,
        input logic [`XLEN-1:0] mi,
        input logic [`XLEN-1:0] wi
    );
        if (writes_rd(mi) && mi[11:7] == rs)
            return ex_pkg::FWD_MEM;
        if (writes_rd(wi) && wi[11:7] == rs)
            return ex_pkg::FWD_WB;
        return ex_pkg::FWD_NONE;
    endfunction

    // funct7[5] selects SUB only for register form
    function automatic ex_pkg::alu_op_e alu_decode(
        input logic [2:0] f3,
        input logic       f7b5,
        input logic       is_reg
    );
        ex_pkg::alu_op_e op;
        case (f3)
            3'b000:  op = (is_reg && f7b5) ? ex_pkg::SUB : ex_pkg::ADD;
            3'b001:  op = ex_pkg::SLL;
            3'b010:  op = ex_pkg::SLT;
            3'b011:  op = ex_pkg::SLTU;
            3'b100:  op = ex_pkg::XOR;
            3'b101:  op = f7b5 ? ex_pkg::SRA : ex_pkg::SRL;
            3'b110:  op = ex_pkg::OR;
            default: op = ex_pkg::AND;
        endcase
        return op;
    endfunction

    assign opcode = ex_pkg::opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign fwda = fwd_pick(inst[19:15], mem_inst, wb_inst);
    assign fwdb = fwd_pick(inst[24:20], mem_inst, wb_inst);

    // Operand and operation decode
    always_comb begin
        asel = ex_pkg::A_REG;
        bsel = ex_pkg::B_REG;
        alusel = ex_pkg::ADD;
        use_mul = 1'b0;
        case (opcode)
            ex_pkg::OP: begin
                // M extension, only low product supported
                if (funct7 == 7'b0000001)
                    use_mul = 1'b1;
                else
                    alusel = alu_decode(funct3, funct7[5], 1'b1);
            end
            ex_pkg::OP_IMM: begin
                bsel = ex_pkg::B_IMM;
                alusel = alu_decode(funct3, funct7[5], 1'b0);
            end
            ex_pkg::LUI: begin
                bsel = ex_pkg::B_IMM;
                alusel = ex_pkg::PASS_B;
            end
            ex_pkg::AUIPC: begin
                asel = ex_pkg::A_PC;
                bsel = ex_pkg::B_IMM;
            end
            ex_pkg::BRANCH: begin
                // Target follows actual outcome
                asel = ex_pkg::A_PC;
                bsel = br_actual ? ex_pkg::B_IMM : ex_pkg::B_FOUR;
            end
            default: ;
        endcase
    end

    // BLTU/BGEU compare unsigned
    assign brun = funct3[1];
    assign is_branch = (opcode == ex_pkg::BRANCH);

    always_comb begin
        case (funct3)
            3'b000:         br_actual = breq;
            3'b001:         br_actual = ~breq;
            3'b100, 3'b110: br_actual = brlt;
            3'b101, 3'b111: br_actual = ~brlt;
            default:        br_actual = 1'b0;
        endcase
    end

    // Mispredict in either direction redirects fetch
    assign redirect_pc = is_branch & (br_actual != br_taken);
    assign br_suc = is_branch & (br_actual == br_taken);
    assign flush = redirect_pc;

    // Busy seen last cycle means the MUL in EX was already issued
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_q <= 1'b0;
        end else begin
            busy_q <= mul_busy;
        end
    end

    assign mul_start = use_mul & ~busy_q;

endmodule

// File: verilog/mul_unit.sv
`timescale 1ns/10ps
`include "ex_macros.svh"

module mul_unit (
    input  logic             clk,
    input  logic             arst_n,
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    input  logic             start,
    output logic [`XLEN-1:0] res,
    output logic             busy
);

    localparam int CW = $clog2(`MUL_CYCLES);

    ex_pkg::mul_state_e state;
    logic [CW-1:0]      cnt;
    logic [`XLEN-1:0]   acc;
    logic [`XLEN-1:0]   mcand;
    logic [`XLEN-1:0]   mplier;
    logic               go;

    assign go = (state == ex_pkg::MUL_IDLE) & start;

    // Start cycle does the first iteration, BUSY does the rest
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ex_pkg::MUL_IDLE;
            cnt <= '0;
        end else begin
            case (state)
                ex_pkg::MUL_IDLE: begin
                    if (start) begin
                        state <= ex_pkg::MUL_BUSY;
                        cnt <= CW'(`MUL_CYCLES - 1);
                    end
                end
                ex_pkg::MUL_BUSY: begin
                    cnt <= cnt - 1'b1;
                    // Last iteration
                    if (cnt == CW'(1))
                        state <= ex_pkg::MUL_DONE;
                end
                ex_pkg::MUL_DONE: state <= ex_pkg::MUL_IDLE;
                default:          state <= ex_pkg::MUL_IDLE;
            endcase
        end
    end

    // Shift-add, low XLEN bits kept
    always_ff @(posedge clk) begin
        if (go) begin
            acc <= a[0] ? b : '0;
            mcand <= b << 1;
            mplier <= a >> 1;
        end else if (state == ex_pkg::MUL_BUSY) begin
            if (mplier[0])
                acc <= acc + mcand;
            mcand <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // Product valid in MUL_DONE
    assign res = acc;
    assign busy = go | (state == ex_pkg::MUL_BUSY);

endmodule

// File: verilog/alu.sv
`timescale 1ns/10ps
`include "ex_macros.svh"

module alu (
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    input  ex_pkg::alu_op_e  sel,
    input  logic             un,
    output logic [`XLEN-1:0] res,
    output logic             eq,
    output logic             lt
);

    localparam int SHW = $clog2(`XLEN);

    logic [SHW-1:0] shamt;
    logic           slt_s;
    logic           slt_u;

    // Shift amount is the low bits of b
    assign shamt = b[SHW-1:0];
    assign slt_s = $signed(a) < $signed(b);
    assign slt_u = a < b;

    always_comb begin
        case (sel)
            ex_pkg::ADD:    res = a + b;
            ex_pkg::SUB:    res = a - b;
            ex_pkg::SLL:    res = a << shamt;
            ex_pkg::SLT:    res = {{(`XLEN-1){1'b0}}, slt_s};
            ex_pkg::SLTU:   res = {{(`XLEN-1){1'b0}}, slt_u};
            ex_pkg::XOR:    res = a ^ b;
            ex_pkg::SRL:    res = a >> shamt;
            // Arithmetic shift keeps sign
            ex_pkg::SRA:    res = $signed(a) >>> shamt;
            ex_pkg::OR:     res = a | b;
            ex_pkg::AND:    res = a & b;
            ex_pkg::PASS_B: res = b;
            default:        res = a + b;
        endcase
    end

    // Branch comparator on the same operands
    assign eq = (a == b);
    assign lt = un ? slt_u : slt_s;

endmodule

// File: verilog/ex_pkg.sv
package ex_pkg;

    // Major opcodes handled by EX
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        PASS_B
    } alu_op_e;

    // Operand source for rs1/rs2
    typedef enum logic [1:0] {
        FWD_NONE,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

    typedef enum logic {
        A_REG,
        A_PC
    } a_sel_e;

    // B_FOUR gives the fall-through target
    typedef enum logic [1:0] {
        B_REG,
        B_IMM,
        B_FOUR
    } b_sel_e;

    typedef enum logic [1:0] {
        MUL_IDLE,
        MUL_BUSY,
        MUL_DONE
    } mul_state_e;

endpackage

// File: verilog/ex_macros.svh
`ifndef EX_MACROS_SVH
`define EX_MACROS_SVH

// Integer datapath width
`define XLEN 32

// Bubble encoding, addi x0,x0,0
`define NOP 32'h00000013

// Shift-add iterations, one product bit each
`define MUL_CYCLES 32

`endif
